// File: include/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data path and program memory geometry
`define WORD_W 16
`define PADDR_W 8
`define PWORD_W (8 + `WORD_W)

// Stack depths
`define DSTACK_DEPTH 16
`define CSTACK_DEPTH 4
`define LSTACK_DEPTH 3

`endif

// File: logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // Instruction classes in the upper nibble of the opcode
  localparam logic [3:0] CLS_CTRL  = 4'h0;
  localparam logic [3:0] CLS_STACK = 4'h1;
  localparam logic [3:0] CLS_ALU   = 4'h2;

  // ALU operations, lower nibble of an ALU class opcode
  localparam logic [3:0] OP_ADD = 4'h0;
  localparam logic [3:0] OP_SUB = 4'h1;
  localparam logic [3:0] OP_AND = 4'h2;
  localparam logic [3:0] OP_OR  = 4'h3;
  localparam logic [3:0] OP_XOR = 4'h4;
  localparam logic [3:0] OP_SHL = 4'h5;

  // Stack operations
  localparam logic [3:0] OP_PUSHI = 4'h0;
  localparam logic [3:0] OP_DROP  = 4'h1;
  localparam logic [3:0] OP_DUP   = 4'h2;
  localparam logic [3:0] OP_SWAP  = 4'h3;
  localparam logic [3:0] OP_OVER  = 4'h4;
  localparam logic [3:0] OP_ITER  = 4'h5;

  // Control operations; the all-zero opcode is NOP
  localparam logic [3:0] OP_NOP   = 4'h0;
  localparam logic [3:0] OP_JMPI  = 4'h1;
  localparam logic [3:0] OP_BZ    = 4'h2;
  localparam logic [3:0] OP_CALLI = 4'h3;
  localparam logic [3:0] OP_RET   = 4'h4;
  localparam logic [3:0] OP_LOOP  = 4'h5;
  localparam logic [3:0] OP_BREAK = 4'h6;
  localparam logic [3:0] OP_CONT  = 4'h7;
  localparam logic [3:0] OP_OUT   = 4'h8;
  localparam logic [3:0] OP_HALT  = 4'h9;

  typedef struct packed {
    logic [3:0] cls;
    logic [3:0] alu_op;
  } alu_view_t;

  typedef struct packed {
    logic [3:0] cls;
    logic [3:0] op;
  } ctrl_view_t;

  // The lower nibble means an ALU operation or a stack/control operation
  typedef union packed {
    alu_view_t  alu;
    ctrl_view_t ctrl;
  } opcode_u;

endpackage

`default_nettype wire

// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

  // Data stack movements
  localparam logic [1:0] MOVE_HOLD = 2'd0;
  localparam logic [1:0] MOVE_PUSH = 2'd1;
  localparam logic [1:0] MOVE_POP  = 2'd2;
  // Pops two operands and pushes one result
  localparam logic [1:0] MOVE_POP2 = 2'd3;

  // Sources for the value written as the new top
  localparam logic [2:0] SRC_IMM    = 3'd0;
  localparam logic [2:0] SRC_ALU    = 3'd1;
  localparam logic [2:0] SRC_TOP    = 3'd2;
  localparam logic [2:0] SRC_SECOND = 3'd3;
  localparam logic [2:0] SRC_ITER   = 3'd4;

endpackage

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module alu import isa_pkg::*; (
  // Second entry of the data stack
  input  logic [`WORD_W-1:0] a,
  // Top entry of the data stack
  input  logic [`WORD_W-1:0] b,
  input  logic [3:0]         alu_op,
  output logic [`WORD_W-1:0] result
);

  // All arithmetic wraps at the word width
  always_comb begin
    case (alu_op)
      OP_ADD: begin
        result = a + b;
      end
      OP_SUB: begin
        result = a - b;
      end
      OP_AND: begin
        result = a & b;
      end
      OP_OR: begin
        result = a | b;
      end
      OP_XOR: begin
        result = a ^ b;
      end
      OP_SHL: begin
        result = {b[`WORD_W-2:0], 1'b0};
      end
      default: begin
        result = b;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/data_stack.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module data_stack import core_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic [1:0]         stack_move,
  input  logic [2:0]         top_src,
  input  logic [`WORD_W-1:0] imm,
  input  logic [`WORD_W-1:0] alu_result,
  input  logic [`WORD_W-1:0] iter_value,
  output logic [`WORD_W-1:0] top,
  output logic [`WORD_W-1:0] second
);

  localparam int DEPTH_W = $clog2(`DSTACK_DEPTH + 1);
  localparam int IDX_W   = $clog2(`DSTACK_DEPTH);

  logic [`WORD_W-1:0] mem [`DSTACK_DEPTH];
  // Number of live entries, the top sits at depth - 1
  logic [DEPTH_W-1:0] depth;
  logic [IDX_W-1:0]   push_idx;
  logic [IDX_W-1:0]   top_idx;
  logic [IDX_W-1:0]   second_idx;
  logic [`WORD_W-1:0] new_top;

  assign push_idx   = IDX_W'(depth);
  assign top_idx    = IDX_W'(depth - 1'b1);
  assign second_idx = IDX_W'(depth - 2'd2);

  assign top    = mem[top_idx];
  assign second = mem[second_idx];

  always_comb begin
    case (top_src)
      SRC_IMM:    new_top = imm;
      SRC_ALU:    new_top = alu_result;
      SRC_SECOND: new_top = second;
      SRC_ITER:   new_top = iter_value;
      default:    new_top = top;
    endcase
  end

  always_ff @(posedge clk) begin
    case (stack_move)
      MOVE_PUSH: mem[push_idx] <= new_top;
      MOVE_HOLD: begin
        if (top_src != SRC_TOP) begin
          mem[top_idx] <= new_top;
        end
        // Swap: the old top drops into the second slot
        if (top_src == SRC_SECOND) begin
          mem[second_idx] <= top;
        end
      end
      MOVE_POP2: mem[second_idx] <= new_top;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      depth <= '0;
    end else if (stack_move == MOVE_PUSH) begin
      depth <= depth + 1'b1;
    end else if (stack_move == MOVE_POP || stack_move == MOVE_POP2) begin
      depth <= depth - 1'b1;
    end
  end

  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    (stack_move == MOVE_POP |-> depth >= 1) and (stack_move == MOVE_POP2 |-> depth >= 2))
    else $error("data stack underflow");

  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    stack_move == MOVE_PUSH |-> depth < `DSTACK_DEPTH)
    else $error("data stack overflow");

endmodule

`default_nettype wire

// File: logic/loop_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module loop_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                loop_start,
  input  logic                loop_break,
  input  logic                loop_cont,
  input  logic [`WORD_W-1:0]  count,
  input  logic [`PADDR_W-1:0] end_addr,
  input  logic [`PADDR_W-1:0] pc_advance,
  output logic                loop_redirect,
  output logic [`PADDR_W-1:0] loop_target,
  output logic [`WORD_W-1:0]  loop_index
);

  localparam int FRAME_W = 2 * `PADDR_W + 2 * `WORD_W;
  localparam int LSP_W   = $clog2(`LSTACK_DEPTH + 1);
  localparam int LIDX_W  = $clog2(`LSTACK_DEPTH);

  // Active loop context
  logic                active;
  logic [`PADDR_W-1:0] start_r;
  logic [`PADDR_W-1:0] end_r;
  logic [`WORD_W-1:0]  total;
  logic [`WORD_W-1:0]  index;

  logic [FRAME_W-1:0]  lstack [`LSTACK_DEPTH];
  logic [LSP_W-1:0]    lsp;
  logic [`WORD_W-1:0]  index_next;
  logic                next_iter;
  logic                loop_exit;

  assign index_next = index + 1'b1;
  // The back edge is taken after the last body word or on CONT
  assign next_iter  = active && !loop_start && (loop_cont || pc_advance == end_r);
  assign loop_exit  = active && !loop_start &&
                      (loop_break || (next_iter && index_next == total));

  assign loop_redirect = next_iter || loop_exit;
  assign loop_target   = loop_exit ? end_r : start_r;
  assign loop_index    = index;

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      lsp    <= '0;
    end else if (loop_start) begin
      active <= 1'b1;
      // Only a running outer loop needs saving
      if (active) begin
        lsp <= lsp + 1'b1;
      end
    end else if (loop_exit) begin
      if (lsp != 0) begin
        lsp <= lsp - 1'b1;
      end else begin
        active <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (loop_start) begin
      if (active) begin
        lstack[LIDX_W'(lsp)] <= {start_r, end_r, total, index};
      end
      start_r <= pc_advance;
      end_r   <= end_addr;
      total   <= count;
      index   <= '0;
    end else if (loop_exit) begin
      // The outermost loop has no saved outer context
      if (lsp != 0) begin
        {start_r, end_r, total, index} <= lstack[LIDX_W'(lsp - 1'b1)];
      end
    end else if (next_iter) begin
      index <= index_next;
    end
  end

  a_loop_nesting: assert property (@(posedge clk) disable iff (rst)
    (loop_start |-> !(active && lsp == `LSTACK_DEPTH)) and (loop_break |-> active))
    else $error("loop nesting too deep or BREAK outside a loop");

endmodule

`default_nettype wire

// File: logic/pc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module pc_sequencer (
  input  logic                clk,
  input  logic                rst,
  input  logic [`WORD_W-1:0]  imm,
  input  logic                jump,
  input  logic                branch_taken,
  input  logic                call,
  input  logic                ret,
  input  logic                halt,
  input  logic                loop_redirect,
  input  logic [`PADDR_W-1:0] loop_target,
  output logic [`PADDR_W-1:0] prog_addr,
  output logic [`PADDR_W-1:0] pc_advance,
  output logic                fetch_valid
);

  localparam int CSP_W  = $clog2(`CSTACK_DEPTH + 1);
  localparam int CIDX_W = $clog2(`CSTACK_DEPTH);

  // Address of the instruction whose word is on prog_data
  logic [`PADDR_W-1:0] pc;
  logic [`PADDR_W-1:0] pc_next;
  logic [`PADDR_W-1:0] imm_addr;
  logic [`PADDR_W-1:0] ret_addr;
  logic [`PADDR_W-1:0] cstack [`CSTACK_DEPTH];
  logic [CSP_W-1:0]    csp;

  assign pc_advance = pc + 1'b1;
  assign imm_addr   = imm[`PADDR_W-1:0];
  assign ret_addr   = cstack[CIDX_W'(csp - 1'b1)];

  // Holding while fetch_valid is low keeps address 0 presented until it is fetched
  always_comb begin
    if (halt || !fetch_valid) begin
      pc_next = pc;
    end else if (ret) begin
      pc_next = ret_addr;
    end else if (jump || call || branch_taken) begin
      pc_next = imm_addr;
    end else if (loop_redirect) begin
      pc_next = loop_target;
    end else begin
      pc_next = pc_advance;
    end
  end

  assign prog_addr = rst ? '0 : pc_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc          <= '0;
      fetch_valid <= 1'b0;
      csp         <= '0;
    end else begin
      pc          <= pc_next;
      fetch_valid <= 1'b1;
      if (call) begin
        csp <= csp + 1'b1;
      end else if (ret) begin
        csp <= csp - 1'b1;
      end
    end
  end

  // Return addresses point just past the calling instruction
  always_ff @(posedge clk) begin
    if (call) begin
      cstack[CIDX_W'(csp)] <= pc_advance;
    end
  end

  a_cstack_bounds: assert property (@(posedge clk) disable iff (rst)
    (ret |-> csp != 0) and (call |-> csp != `CSTACK_DEPTH))
    else $error("call stack overflow or underflow");

endmodule

`default_nettype wire

// File: logic/exec_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module exec_decode import isa_pkg::*, core_pkg::*; (
  input  opcode_u            opcode,
  input  logic               fetch_valid,
  input  logic [`WORD_W-1:0] top,
  output logic [1:0]         stack_move,
  output logic [2:0]         top_src,
  output logic [3:0]         alu_op,
  output logic               jump,
  output logic               branch_taken,
  output logic               call,
  output logic               ret,
  output logic               halt,
  output logic               loop_start,
  output logic               loop_break,
  output logic               loop_cont,
  output logic               out_valid
);

  always_comb begin
    stack_move   = MOVE_HOLD;
    top_src      = SRC_TOP;
    alu_op       = OP_ADD;
    jump         = 1'b0;
    branch_taken = 1'b0;
    call         = 1'b0;
    ret          = 1'b0;
    halt         = 1'b0;
    loop_start   = 1'b0;
    loop_break   = 1'b0;
    loop_cont    = 1'b0;
    out_valid    = 1'b0;

    // An invalid fetch falls through the defaults and behaves as NOP
    if (fetch_valid) begin
      case (opcode.ctrl.cls)
        CLS_ALU: begin
          alu_op  = opcode.alu.alu_op;
          top_src = SRC_ALU;
          case (opcode.alu.alu_op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: stack_move = MOVE_POP2;
            // Shift is unary and rewrites the top in place
            OP_SHL: stack_move = MOVE_HOLD;
            default: top_src = SRC_TOP;
          endcase
        end
        CLS_STACK: begin
          case (opcode.ctrl.op)
            OP_PUSHI: {stack_move, top_src} = {MOVE_PUSH, SRC_IMM};
            OP_DROP:  stack_move = MOVE_POP;
            OP_DUP:   {stack_move, top_src} = {MOVE_PUSH, SRC_TOP};
            // The data stack reads HOLD with SRC_SECOND as an exchange
            OP_SWAP:  {stack_move, top_src} = {MOVE_HOLD, SRC_SECOND};
            OP_OVER:  {stack_move, top_src} = {MOVE_PUSH, SRC_SECOND};
            OP_ITER:  {stack_move, top_src} = {MOVE_PUSH, SRC_ITER};
            default: ;
          endcase
        end
        CLS_CTRL: begin
          case (opcode.ctrl.op)
            OP_JMPI:  jump = 1'b1;
            OP_BZ: begin
              // The tested word is consumed whether or not the branch is taken
              stack_move   = MOVE_POP;
              branch_taken = (top == '0);
            end
            OP_CALLI: call = 1'b1;
            OP_RET:   ret = 1'b1;
            OP_LOOP: begin
              stack_move = MOVE_POP;
              loop_start = 1'b1;
            end
            OP_BREAK: loop_break = 1'b1;
            OP_CONT:  loop_cont = 1'b1;
            OP_OUT:   out_valid = 1'b1;
            OP_HALT:  halt = 1'b1;
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/stack_cpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module stack_cpu import isa_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  output logic [`PADDR_W-1:0] prog_addr,
  input  logic [`PWORD_W-1:0] prog_data,
  output logic                out_valid,
  output logic [`WORD_W-1:0]  out_data,
  output logic                halted
);

  opcode_u               opcode;
  logic [`WORD_W-1:0]    imm;
  logic [`PADDR_W-1:0]   pc_advance;
  logic                  fetch_valid;
  logic [1:0]            stack_move;
  logic [2:0]            top_src;
  logic [3:0]            alu_op;
  logic                  jump;
  logic                  branch_taken;
  logic                  call;
  logic                  ret;
  logic                  halt;
  logic                  loop_start;
  logic                  loop_break;
  logic                  loop_cont;
  logic [`WORD_W-1:0]    top;
  logic [`WORD_W-1:0]    second;
  logic [`WORD_W-1:0]    alu_result;
  logic                  loop_redirect;
  logic [`PADDR_W-1:0]   loop_target;
  logic [`WORD_W-1:0]    loop_index;

  // Program word layout is the immediate above the opcode byte
  assign opcode = prog_data[7:0];
  assign imm    = prog_data[`PWORD_W-1:8];

  assign out_data = top;
  assign halted   = halt;

  pc_sequencer pc_sequencer_i (
    .clk, .rst, .imm, .jump, .branch_taken, .call, .ret, .halt,
    .loop_redirect, .loop_target, .prog_addr, .pc_advance, .fetch_valid
  );

  exec_decode exec_decode_i (
    .opcode, .fetch_valid, .top, .stack_move, .top_src, .alu_op,
    .jump, .branch_taken, .call, .ret, .halt,
    .loop_start, .loop_break, .loop_cont, .out_valid
  );

  alu alu_i (
    .a(second),
    .b(top),
    .alu_op,
    .result(alu_result)
  );

  data_stack data_stack_i (
    .clk, .rst, .stack_move, .top_src, .imm, .alu_result,
    .iter_value(loop_index), .top, .second
  );

  loop_unit loop_unit_i (
    .clk, .rst, .loop_start, .loop_break, .loop_cont,
    .count(top),
    .end_addr(imm[`PADDR_W-1:0]),
    .pc_advance, .loop_redirect, .loop_target, .loop_index
  );

endmodule

`default_nettype wire

// File: test/stack_cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module stack_cpu_tb import isa_pkg::*; ();

  localparam int CLK_PERIOD = 20;

  logic                clk;
  logic                rst;
  logic [`PADDR_W-1:0] prog_addr;
  logic [`PWORD_W-1:0] prog_data;
  logic                out_valid;
  logic [`WORD_W-1:0]  out_data;
  logic                halted;

  logic [`PWORD_W-1:0] pmem [1 << `PADDR_W];
  logic [`PADDR_W-1:0] fetch_addr;
  logic [`WORD_W-1:0]  exp_q [$];
  logic [`WORD_W-1:0]  exp_head;
  int                  exp_left;
  int                  asm_pc;
  int                  prog_len;
  integer              seed;
  logic [3:0]          arith_ops [6];

  stack_cpu stack_cpu_i (
    .clk, .rst, .prog_addr, .prog_data, .out_valid, .out_data, .halted
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // The address is captured at the rising edge and its word appears at the falling edge
  always @(posedge clk) begin
    fetch_addr <= prog_addr;
  end

  always @(negedge clk) begin
    prog_data <= pmem[fetch_addr];
  end

  // Head of the expected OUT sequence as seen by the next rising edge
  always @(posedge clk) begin
    if (!rst && out_valid && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
    end
    exp_left <= exp_q.size();
    exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Operand a is the second stack entry and b the top
  function automatic logic [`WORD_W-1:0] alu_model(input logic [3:0] op,
                                                   input logic [`WORD_W-1:0] a,
                                                   input logic [`WORD_W-1:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      default: return b << 1;
    endcase
  endfunction

  task automatic assemble(input logic [3:0] cls, input logic [3:0] op,
                          input logic [`WORD_W-1:0] imm);
    opcode_u oc;
    oc.ctrl.cls  = cls;
    oc.ctrl.op   = op;
    pmem[asm_pc] = {imm, oc};
    asm_pc++;
  endtask

  task automatic alu_instr(input logic [3:0] op);
    opcode_u oc;
    oc.alu.cls    = CLS_ALU;
    oc.alu.alu_op = op;
    pmem[asm_pc]  = {`WORD_W'(0), oc};
    asm_pc++;
  endtask

  task automatic push_imm(input int v);
    assemble(CLS_STACK, OP_PUSHI, `WORD_W'(v));
  endtask

  task automatic shuffle(input logic [3:0] op);
    assemble(CLS_STACK, op, '0);
  endtask

  task automatic control(input logic [3:0] op, input int target);
    assemble(CLS_CTRL, op, `WORD_W'(target));
  endtask

  // Three words that show a constant and leave the stack as it was
  task automatic out_const(input int v);
    push_imm(v);
    control(OP_OUT, 0);
    shuffle(OP_DROP);
  endtask

  a_out_value: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> exp_left != 0 && out_data == exp_head)
    else fail_now($sformatf("FAIL %0t: out_data %h, expected %h with %0d outputs pending",
                            $time, $sampled(out_data), $sampled(exp_head),
                            $sampled(exp_left)));

  a_halt_holds: assert property (@(posedge clk) disable iff (rst)
    halted |=> halted && $stable(prog_addr) && !out_valid)
    else fail_now($sformatf("FAIL %0t: core left the halted state", $time));

  initial begin
    int ra;
    int rb;
    int base;
    rst       = 1'b1;
    prog_data = '0;
    seed      = 92;
    asm_pc    = 0;
    arith_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL};
    // Stray fetches land on HALT words that carry their own address
    for (int i = 0; i < (1 << `PADDR_W); i++) begin
      pmem[i] = {`WORD_W'(i), CLS_CTRL, OP_HALT};
    end

    // Every ALU operation on random operands, SHL takes only the top
    for (int k = 0; k < 6; k++) begin
      ra = $random(seed);
      rb = $random(seed);
      if (arith_ops[k] != OP_SHL) begin
        push_imm(ra);
      end
      push_imm(rb);
      alu_instr(arith_ops[k]);
      control(OP_OUT, 0);
      shuffle(OP_DROP);
      exp_q.push_back(alu_model(arith_ops[k], `WORD_W'(ra), `WORD_W'(rb)));
    end

    // Shuffles starting from a b with b on top
    ra = $random(seed);
    rb = $random(seed);
    push_imm(ra);
    push_imm(rb);
    shuffle(OP_DUP);
    control(OP_OUT, 0);
    shuffle(OP_DROP);
    shuffle(OP_SWAP);
    control(OP_OUT, 0);
    shuffle(OP_OVER);
    control(OP_OUT, 0);
    shuffle(OP_DROP);
    shuffle(OP_DROP);
    control(OP_OUT, 0);
    shuffle(OP_DROP);
    exp_q.push_back(`WORD_W'(rb));
    exp_q.push_back(`WORD_W'(ra));
    exp_q.push_back(`WORD_W'(rb));
    exp_q.push_back(`WORD_W'(rb));

    // Jump over an OUT, a taken BZ over another, then a BZ that falls through
    push_imm(16'h00f1);
    control(OP_JMPI, asm_pc + 2);
    control(OP_OUT, 0);
    push_imm(0);
    control(OP_BZ, asm_pc + 2);
    control(OP_OUT, 0);
    push_imm(5);
    control(OP_BZ, asm_pc + 2);
    control(OP_OUT, 0);
    shuffle(OP_DROP);
    exp_q.push_back(16'h00f1);

    // Three nested subroutines placed behind a jump to the caller
    base = asm_pc;
    control(OP_JMPI, base + 21);
    out_const(16'h0011);
    control(OP_CALLI, base + 9);
    out_const(16'h0014);
    control(OP_RET, 0);
    out_const(16'h0012);
    control(OP_CALLI, base + 17);
    out_const(16'h0013);
    control(OP_RET, 0);
    out_const(16'h0030);
    control(OP_RET, 0);
    control(OP_CALLI, base + 1);
    out_const(16'h0055);
    exp_q.push_back(16'h0011);
    exp_q.push_back(16'h0012);
    exp_q.push_back(16'h0030);
    exp_q.push_back(16'h0013);
    exp_q.push_back(16'h0014);
    exp_q.push_back(16'h0055);

    // Plain loop of three showing its index
    push_imm(3);
    control(OP_LOOP, asm_pc + 4);
    shuffle(OP_ITER);
    control(OP_OUT, 0);
    shuffle(OP_DROP);
    for (int i = 0; i < 3; i++) begin
      exp_q.push_back(`WORD_W'(i));
    end

    // Outer loop of two around an inner loop of three, then the outer index
    push_imm(2);
    control(OP_LOOP, asm_pc + 9);
    push_imm(3);
    control(OP_LOOP, asm_pc + 4);
    shuffle(OP_ITER);
    control(OP_OUT, 0);
    shuffle(OP_DROP);
    shuffle(OP_ITER);
    control(OP_OUT, 0);
    shuffle(OP_DROP);
    for (int o = 0; o < 2; o++) begin
      for (int i = 0; i < 3; i++) begin
        exp_q.push_back(`WORD_W'(i));
      end
      exp_q.push_back(`WORD_W'(o));
    end

    // Loop of six that breaks once index 3 has been shown
    push_imm(6);
    base = asm_pc;
    control(OP_LOOP, base + 9);
    shuffle(OP_ITER);
    control(OP_OUT, 0);
    push_imm(3);
    alu_instr(OP_SUB);
    control(OP_BZ, base + 7);
    control(OP_JMPI, base + 8);
    control(OP_BREAK, 0);
    control(OP_NOP, 0);
    for (int i = 0; i < 4; i++) begin
      exp_q.push_back(`WORD_W'(i));
    end

    // CONT skips the trailing OUT on every pass
    push_imm(4);
    control(OP_LOOP, asm_pc + 8);
    shuffle(OP_ITER);
    control(OP_OUT, 0);
    shuffle(OP_DROP);
    control(OP_CONT, 0);
    out_const(16'hdead);
    for (int i = 0; i < 4; i++) begin
      exp_q.push_back(`WORD_W'(i));
    end

    out_const(16'h0aa0);
    exp_q.push_back(16'h0aa0);
    control(OP_HALT, 0);
    prog_len = asm_pc;

    repeat (4) @(negedge clk);
    rst = 1'b0;
    do begin
      @(posedge clk);
    end while (!halted);
    // Stay a while in HALT so the hold checks get to run
    repeat (10) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      fail_now($sformatf("Core halted with %0d expected outputs never shown", exp_q.size()));
    end
  end

  initial begin
    #1;
    #(prog_len * 50 * CLK_PERIOD);
    fail_now($sformatf("Timeout after %0d cycles without reaching HALT", prog_len * 50));
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
logic/isa_pkg.sv
logic/core_pkg.sv
logic/alu.sv
logic/data_stack.sv
logic/loop_unit.sv
logic/pc_sequencer.sv
logic/exec_decode.sv
logic/stack_cpu.sv
test/stack_cpu_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module stack_cpu_tb \
  -f build.f -o stack_cpu_sim &&
./obj_dir/stack_cpu_sim ||
{ echo "stack_cpu simulation did not pass"; exit 1; }
